//--- logic/cluster_cfg_pkg.sv
package cluster_cfg_pkg;

  //////////////////////////////////////////////////
  // Cluster sizes

  localparam int N_SLOTS = 4;
  localparam int SLOT_W = 2;

  // Per-slot word memory
  localparam int MEM_WORDS = 64;
  localparam int WORD_AW = 6;
  localparam int DATA_W = 32;

  // Descriptor fields
  localparam int TAG_W = 8;
  localparam int LEN_W = 6;

  //////////////////////////////////////////////////
  // Host address split

  // Slot index sits above the word index
  localparam int ADR_W = SLOT_W + WORD_AW;

endpackage

//--- logic/cluster_msg_pkg.sv
package cluster_msg_pkg;

  import cluster_cfg_pkg::*;

  //////////////////////////////////////////////////
  // Wishbone, per slot

  // cyc is folded into stb
  typedef struct packed {
    logic               stb;
    logic               we;
    logic [WORD_AW-1:0] word;
    logic [DATA_W-1:0]  dat;
  } wb_req_t;

  typedef struct packed {
    logic              ack;
    logic [DATA_W-1:0] dat;
  } wb_rsp_t;

  //////////////////////////////////////////////////
  // Descriptors

  // Length of zero gives an empty sum
  typedef struct packed {
    logic [TAG_W-1:0]   tag;
    logic [SLOT_W-1:0]  slot;
    logic [WORD_AW-1:0] start;
    logic [LEN_W-1:0]   len;
  } work_desc_t;

  typedef struct packed {
    logic [TAG_W-1:0]  tag;
    logic [SLOT_W-1:0] slot;
    logic [DATA_W-1:0] sum;
  } result_desc_t;

endpackage

//--- logic/pipe_reg.sv
`timescale 1ns/1ns

module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     arst_n,

  input  payload_t s_data,
  input  logic     s_valid,
  output logic     s_ready,

  output payload_t m_data,
  output logic     m_valid,
  input  logic     m_ready
);

  logic load;

  // Free slot, or the held item leaves this cycle
  assign s_ready = !m_valid || m_ready;
  assign load = s_valid && s_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      m_valid <= 1'b0;
    end else if (load) begin
      m_valid <= 1'b1;
    end else if (m_ready) begin
      m_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      m_data <= s_data;
    end
  end

endmodule

//--- logic/slot_core.sv
`timescale 1ns/1ns

module slot_core (
  input  logic                          clk,
  input  logic                          arst_n,

  input  cluster_msg_pkg::wb_req_t      wb_req,
  output cluster_msg_pkg::wb_rsp_t      wb_rsp,

  input  cluster_msg_pkg::work_desc_t   desc,
  input  logic                          desc_valid,
  output logic                          desc_ready,

  output cluster_msg_pkg::result_desc_t result,
  output logic                          result_valid,
  input  logic                          result_ready
);

  import cluster_cfg_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RUN,
    ST_DONE
  } state_t;

  logic [DATA_W-1:0]  mem [MEM_WORDS];
  state_t             state;
  logic               rsp_ack;
  logic [DATA_W-1:0]  rsp_dat;
  logic [WORD_AW-1:0] ptr;
  logic [LEN_W-1:0]   remain;
  logic [DATA_W-1:0]  acc;
  logic [TAG_W-1:0]   job_tag;
  logic [SLOT_W-1:0]  job_slot;
  logic               take;
  logic               step;

  assign desc_ready = (state == ST_IDLE);
  assign take = desc_valid && desc_ready;

  // Host owns the port this cycle, engine waits
  assign step = (state == ST_RUN) && (remain != '0) && !wb_req.stb;

  //////////////////////////////////////////////////
  // Host access

  always_ff @(posedge clk) begin
    if (wb_req.stb) begin
      if (wb_req.we) begin
        mem[wb_req.word] <= wb_req.dat;
      end
      rsp_dat <= mem[wb_req.word];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rsp_ack <= 1'b0;
    end else begin
      rsp_ack <= wb_req.stb;
    end
  end

  assign wb_rsp = '{ack: rsp_ack, dat: rsp_dat};

  //////////////////////////////////////////////////
  // Summing engine

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: if (take) state <= ST_RUN;
        ST_RUN:  if (remain == '0) state <= ST_DONE;
        ST_DONE: if (result_ready) state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Pointer wraps at MEM_WORDS on its own
  always_ff @(posedge clk) begin
    if (take) begin
      job_tag  <= desc.tag;
      job_slot <= desc.slot;
      ptr      <= desc.start;
      remain   <= desc.len;
      acc      <= '0;
    end else if (step) begin
      acc    <= acc + mem[ptr];
      ptr    <= ptr + 1'b1;
      remain <= remain - 1'b1;
    end
  end

  assign result_valid = (state == ST_DONE);
  assign result = '{tag: job_tag, slot: job_slot, sum: acc};

endmodule

//--- logic/slot_wrapper.sv
`timescale 1ns/1ns

module slot_wrapper (
  input  logic                          clk,
  input  logic                          arst_n,

  input  cluster_msg_pkg::wb_req_t      wb_req,
  output cluster_msg_pkg::wb_rsp_t      wb_rsp,

  input  cluster_msg_pkg::work_desc_t   desc,
  input  logic                          desc_valid,
  output logic                          desc_ready,

  output cluster_msg_pkg::result_desc_t result,
  output logic                          result_valid,
  input  logic                          result_ready
);

  import cluster_msg_pkg::*;

  wb_req_t      req_q;
  logic         req_q_valid;
  wb_req_t      core_req;
  wb_rsp_t      core_rsp;
  wb_rsp_t      rsp_q;
  logic         rsp_q_valid;
  work_desc_t   core_desc;
  logic         core_desc_valid;
  logic         core_desc_ready;
  result_desc_t core_result;
  logic         core_result_valid;
  logic         core_result_ready;
  logic         rst_q_valid;
  logic         core_arst_n;

  //////////////////////////////////////////////////
  // Registered reset for the core

  pipe_reg #(.payload_t(logic)) u_rst_reg (
    .clk(clk), .arst_n(arst_n),
    .s_data(1'b1), .s_valid(1'b1), .s_ready(),
    .m_data(), .m_valid(rst_q_valid), .m_ready(1'b1)
  );

  assign core_arst_n = rst_q_valid;

  //////////////////////////////////////////////////
  // Host side, never stalls

  pipe_reg #(.payload_t(wb_req_t)) u_req_reg (
    .clk(clk), .arst_n(arst_n),
    .s_data(wb_req), .s_valid(wb_req.stb), .s_ready(),
    .m_data(req_q), .m_valid(req_q_valid), .m_ready(1'b1)
  );

  assign core_req = '{stb: req_q_valid, we: req_q.we, word: req_q.word, dat: req_q.dat};

  pipe_reg #(.payload_t(wb_rsp_t)) u_rsp_reg (
    .clk(clk), .arst_n(arst_n),
    .s_data(core_rsp), .s_valid(core_rsp.ack), .s_ready(),
    .m_data(rsp_q), .m_valid(rsp_q_valid), .m_ready(1'b1)
  );

  assign wb_rsp = '{ack: rsp_q_valid, dat: rsp_q.dat};

  //////////////////////////////////////////////////
  // Descriptor streams

  pipe_reg #(.payload_t(work_desc_t)) u_desc_reg (
    .clk(clk), .arst_n(arst_n),
    .s_data(desc), .s_valid(desc_valid), .s_ready(desc_ready),
    .m_data(core_desc), .m_valid(core_desc_valid), .m_ready(core_desc_ready)
  );

  pipe_reg #(.payload_t(result_desc_t)) u_result_reg (
    .clk(clk), .arst_n(arst_n),
    .s_data(core_result), .s_valid(core_result_valid), .s_ready(core_result_ready),
    .m_data(result), .m_valid(result_valid), .m_ready(result_ready)
  );

  slot_core u_core (
    .clk          (clk),
    .arst_n       (core_arst_n),
    .wb_req       (core_req),
    .wb_rsp       (core_rsp),
    .desc         (core_desc),
    .desc_valid   (core_desc_valid),
    .desc_ready   (core_desc_ready),
    .result       (core_result),
    .result_valid (core_result_valid),
    .result_ready (core_result_ready)
  );

endmodule

//--- logic/slot_dispatch.sv
`timescale 1ns/1ns

module slot_dispatch (
  input  logic                                   clk,
  input  logic                                   arst_n,

  input  logic                                   wb_cyc,
  input  logic                                   wb_stb,
  input  logic                                   wb_we,
  input  logic [cluster_cfg_pkg::ADR_W-1:0]      wb_adr,
  input  logic [cluster_cfg_pkg::DATA_W-1:0]     wb_dat_w,
  output logic [cluster_cfg_pkg::DATA_W-1:0]     wb_dat_r,
  output logic                                   wb_ack,

  input  cluster_msg_pkg::work_desc_t            in_desc,
  input  logic                                   in_valid,
  output logic                                   in_ready,

  output cluster_msg_pkg::wb_req_t               slot_wb_req [cluster_cfg_pkg::N_SLOTS],
  input  cluster_msg_pkg::wb_rsp_t               slot_wb_rsp [cluster_cfg_pkg::N_SLOTS],
  output cluster_msg_pkg::work_desc_t            slot_desc,
  output logic [cluster_cfg_pkg::N_SLOTS-1:0]    slot_desc_valid,
  input  logic [cluster_cfg_pkg::N_SLOTS-1:0]    slot_desc_ready
);

  import cluster_cfg_pkg::*;

  logic              pending;
  logic              issue;
  logic [SLOT_W-1:0] adr_slot;
  logic [SLOT_W-1:0] pend_slot;

  assign adr_slot = wb_adr[ADR_W-1:WORD_AW];
  assign issue = wb_cyc && wb_stb && !pending;

  // One pulse per host access, then wait for the ack
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pending <= 1'b0;
    end else if (issue) begin
      pending <= 1'b1;
    end else if (wb_ack) begin
      pending <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      pend_slot <= adr_slot;
    end
  end

  assign wb_ack = pending && slot_wb_rsp[pend_slot].ack;
  assign wb_dat_r = slot_wb_rsp[pend_slot].dat;

  assign slot_desc = in_desc;
  assign in_ready = slot_desc_ready[in_desc.slot];

  for (genvar i = 0; i < N_SLOTS; i++) begin : g_route
    assign slot_wb_req[i] = '{
      stb:  issue && (adr_slot == SLOT_W'(i)),
      we:   wb_we,
      word: wb_adr[WORD_AW-1:0],
      dat:  wb_dat_w
    };
    assign slot_desc_valid[i] = in_valid && (in_desc.slot == SLOT_W'(i));
  end

endmodule

//--- logic/result_collect.sv
`timescale 1ns/1ns

module result_collect (
  input  logic                                clk,
  input  logic                                arst_n,

  input  cluster_msg_pkg::result_desc_t       slot_result [cluster_cfg_pkg::N_SLOTS],
  input  logic [cluster_cfg_pkg::N_SLOTS-1:0] slot_valid,
  output logic [cluster_cfg_pkg::N_SLOTS-1:0] slot_ready,

  output cluster_msg_pkg::result_desc_t       out_desc,
  output logic                                out_valid,
  input  logic                                out_ready
);

  import cluster_cfg_pkg::*;

  logic [SLOT_W-1:0] last;
  logic [SLOT_W-1:0] grant;
  logic              found;
  logic              can_load;

  assign can_load = !out_valid || out_ready;

  // Search starts just past the slot served last
  always_comb begin
    logic [SLOT_W-1:0] idx;
    found = 1'b0;
    grant = last;
    for (int k = 1; k <= N_SLOTS; k++) begin
      idx = last + SLOT_W'(k);
      if (!found && slot_valid[idx]) begin
        found = 1'b1;
        grant = idx;
      end
    end
  end

  always_comb begin
    slot_ready = '0;
    if (can_load && found) begin
      slot_ready[grant] = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
      last      <= '0;
    end else if (can_load) begin
      out_valid <= found;
      if (found) begin
        last <= grant;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (can_load && found) begin
      out_desc <= slot_result[grant];
    end
  end

endmodule

//--- logic/cluster_top.sv
`timescale 1ns/1ns

module cluster_top (
  input  logic                               clk,
  input  logic                               arst_n,

  input  logic                               wb_cyc,
  input  logic                               wb_stb,
  input  logic                               wb_we,
  input  logic [cluster_cfg_pkg::ADR_W-1:0]  wb_adr,
  input  logic [cluster_cfg_pkg::DATA_W-1:0] wb_dat_w,
  output logic [cluster_cfg_pkg::DATA_W-1:0] wb_dat_r,
  output logic                               wb_ack,

  input  cluster_msg_pkg::work_desc_t        in_desc,
  input  logic                               in_valid,
  output logic                               in_ready,

  output cluster_msg_pkg::result_desc_t      out_desc,
  output logic                               out_valid,
  input  logic                               out_ready
);

  import cluster_cfg_pkg::*;
  import cluster_msg_pkg::*;

  wb_req_t            slot_wb_req [N_SLOTS];
  wb_rsp_t            slot_wb_rsp [N_SLOTS];
  work_desc_t         slot_desc;
  logic [N_SLOTS-1:0] slot_desc_valid;
  logic [N_SLOTS-1:0] slot_desc_ready;
  result_desc_t       slot_result [N_SLOTS];
  logic [N_SLOTS-1:0] slot_valid;
  logic [N_SLOTS-1:0] slot_ready;

  slot_dispatch u_dispatch (
    .clk(clk), .arst_n(arst_n),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    .in_desc(in_desc), .in_valid(in_valid), .in_ready(in_ready),
    .slot_wb_req(slot_wb_req), .slot_wb_rsp(slot_wb_rsp),
    .slot_desc(slot_desc), .slot_desc_valid(slot_desc_valid),
    .slot_desc_ready(slot_desc_ready)
  );

  for (genvar i = 0; i < N_SLOTS; i++) begin : g_slot
    slot_wrapper u_slot (
      .clk(clk), .arst_n(arst_n),
      .wb_req(slot_wb_req[i]), .wb_rsp(slot_wb_rsp[i]),
      .desc(slot_desc), .desc_valid(slot_desc_valid[i]), .desc_ready(slot_desc_ready[i]),
      .result(slot_result[i]), .result_valid(slot_valid[i]), .result_ready(slot_ready[i])
    );
  end

  result_collect u_collect (
    .clk(clk), .arst_n(arst_n),
    .slot_result(slot_result), .slot_valid(slot_valid), .slot_ready(slot_ready),
    .out_desc(out_desc), .out_valid(out_valid), .out_ready(out_ready)
  );

endmodule

//--- test/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
  parameter int PERIOD = 40,
  parameter int RST_CYCLES = 3
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Release lands just after an edge
  initial begin
    arst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    #2;
    arst_n = 1'b1;
  end

endmodule

//--- test/cluster_top_checker.sv
`timescale 1ns/1ns

module cluster_top_checker (
  input logic                                clk,
  input logic                                arst_n,
  input logic [cluster_cfg_pkg::N_SLOTS-1:0] slot_ready,
  input cluster_msg_pkg::result_desc_t       out_desc,
  input logic                                out_valid,
  input logic                                out_ready
);

  int n_fail = 0;

  // Output held while the sink stalls
  hold_under_stall: assert property (
    @(posedge clk) disable iff (!arst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_desc)
  ) else begin
    n_fail++;
    $error("out_desc or out_valid changed while stalled");
  end

  quiet_in_reset: assert property (
    @(posedge clk) !arst_n |-> !out_valid
  ) else begin
    n_fail++;
    $error("out_valid high during reset");
  end

  // At most one slot granted
  single_grant: assert property (
    @(posedge clk) disable iff (!arst_n)
    $onehot0(slot_ready)
  ) else begin
    n_fail++;
    $error("more than one slot_ready high");
  end

endmodule

//--- test/cluster_top_tb.sv
`timescale 1ns/1ns

module cluster_top_tb;

  import cluster_cfg_pkg::*;
  import cluster_msg_pkg::*;

  localparam int DRIVE_DLY = 2;
  localparam int FILL_OPS = N_SLOTS * MEM_WORDS;
  localparam int N_STEPS = 24;
  localparam int CYCLE_LIMIT = (FILL_OPS + N_STEPS) * (MEM_WORDS + 20);

  typedef enum logic [1:0] {
    OP_WR,
    OP_RD,
    OP_DESC
  } op_kind_t;

  // Data is write value, or expected value of a read
  typedef struct packed {
    op_kind_t           kind;
    logic [SLOT_W-1:0]  slot;
    logic [WORD_AW-1:0] word;
    logic [DATA_W-1:0]  data;
    logic [TAG_W-1:0]   tag;
    logic [LEN_W-1:0]   len;
  } step_t;

  logic               clk;
  logic               arst_n;
  logic               wb_cyc;
  logic               wb_stb;
  logic               wb_we;
  logic [ADR_W-1:0]   wb_adr;
  logic [DATA_W-1:0]  wb_dat_w;
  logic [DATA_W-1:0]  wb_dat_r;
  logic               wb_ack;
  work_desc_t         in_desc;
  logic               in_valid;
  logic               in_ready;
  result_desc_t       out_desc;
  logic               out_valid;
  logic               out_ready;

  step_t              steps [N_STEPS];
  logic [DATA_W-1:0]  model_mem [N_SLOTS*MEM_WORDS];
  result_desc_t       pend_q [$];
  logic [31:0]        lcg_state = 32'd49787;
  logic [31:0]        rnd;
  int                 n_errors = 0;
  int                 n_sent = 0;
  int                 n_results = 0;
  int                 cycles = 0;

  tb_clock #(.PERIOD(40), .RST_CYCLES(3)) u_clock (.clk(clk), .arst_n(arst_n));

  cluster_top u_dut (
    .clk(clk), .arst_n(arst_n),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    .in_desc(in_desc), .in_valid(in_valid), .in_ready(in_ready),
    .out_desc(out_desc), .out_valid(out_valid), .out_ready(out_ready)
  );

  bind result_collect cluster_top_checker u_checker (
    .clk(clk), .arst_n(arst_n), .slot_ready(slot_ready),
    .out_desc(out_desc), .out_valid(out_valid), .out_ready(out_ready)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic [DATA_W-1:0] fill_word(input logic [ADR_W-1:0] adr);
    return (DATA_W'(adr) + 32'd1) * 32'h9e37_79b9;
  endfunction

  // Sum of len words from start, modulo 2^32, word index modulo MEM_WORDS
  function automatic logic [DATA_W-1:0] model_sum(input work_desc_t d);
    logic [DATA_W-1:0] acc;
    int w;
    acc = '0;
    for (int i = 0; i < int'(d.len); i++) begin
      w = (int'(d.start) + i) % MEM_WORDS;
      acc = acc + model_mem[{d.slot, WORD_AW'(w)}];
    end
    return acc;
  endfunction

  function automatic step_t make_step(op_kind_t kind, int slot, int word,
                                     logic [DATA_W-1:0] data, int tag, int len);
    step_t s;
    s.kind = kind;
    s.slot = SLOT_W'(slot);
    s.word = WORD_AW'(word);
    s.data = data;
    s.tag  = TAG_W'(tag);
    s.len  = LEN_W'(len);
    return s;
  endfunction

  //////////////////////////////////////////////////
  // Stimulus table

  task automatic load_steps();
    steps[0]  = make_step(OP_WR,   0,  5, 32'hdead_beef, 0, 0);
    steps[1]  = make_step(OP_WR,   1,  5, 32'h1234_5678, 0, 0);
    steps[2]  = make_step(OP_WR,   2,  5, 32'hffff_ffff, 0, 0);
    steps[3]  = make_step(OP_WR,   3,  5, 32'h0000_0001, 0, 0);
    steps[4]  = make_step(OP_WR,   3, 63, 32'h8000_0000, 0, 0);
    steps[5]  = make_step(OP_WR,   3,  0, 32'h8000_0001, 0, 0);
    steps[6]  = make_step(OP_RD,   0,  5, 32'hdead_beef, 0, 0);
    steps[7]  = make_step(OP_RD,   1,  5, 32'h1234_5678, 0, 0);
    steps[8]  = make_step(OP_RD,   2,  5, 32'hffff_ffff, 0, 0);
    steps[9]  = make_step(OP_RD,   3,  5, 32'h0000_0001, 0, 0);
    steps[10] = make_step(OP_DESC, 0,  0, 32'h0, 'h10, 63);
    steps[11] = make_step(OP_DESC, 1,  2, 32'h0, 'h11, 8);
    steps[12] = make_step(OP_DESC, 2, 60, 32'h0, 'h12, 10);
    steps[13] = make_step(OP_DESC, 3, 62, 32'h0, 'h13, 3);
    // Reads while engines run
    steps[14] = make_step(OP_RD,   0,  5, 32'hdead_beef, 0, 0);
    steps[15] = make_step(OP_RD,   3, 63, 32'h8000_0000, 0, 0);
    steps[16] = make_step(OP_DESC, 1,  7, 32'h0, 'h14, 0);
    steps[17] = make_step(OP_DESC, 1, 40, 32'h0, 'h15, 20);
    steps[18] = make_step(OP_DESC, 2,  0, 32'h0, 'h16, 1);
    steps[19] = make_step(OP_RD,   2,  5, 32'hffff_ffff, 0, 0);
    steps[20] = make_step(OP_DESC, 0, 32, 32'h0, 'h17, 32);
    steps[21] = make_step(OP_DESC, 3, 63, 32'h0, 'h18, 63);
    steps[22] = make_step(OP_RD,   1,  5, 32'h1234_5678, 0, 0);
    steps[23] = make_step(OP_DESC, 0,  5, 32'h0, 'h19, 1);
  endtask

  //////////////////////////////////////////////////
  // Host side

  task automatic wb_access(input logic we, input logic [ADR_W-1:0] adr,
                           input logic [DATA_W-1:0] dat_w, output logic [DATA_W-1:0] dat_r);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = we;
    wb_adr = adr;
    wb_dat_w = dat_w;
    @(negedge clk);
    while (wb_ack !== 1'b1) @(negedge clk);
    dat_r = wb_dat_r;
    @(posedge clk);
    #DRIVE_DLY;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    @(negedge clk);
    if (wb_ack !== 1'b0) begin
      n_errors++;
      $display("ERROR %0t: wb_ack high for more than one cycle", $time);
    end
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic host_write(input logic [ADR_W-1:0] adr, input logic [DATA_W-1:0] data);
    logic [DATA_W-1:0] rd_unused;
    model_mem[adr] = data;
    wb_access(1'b1, adr, data, rd_unused);
  endtask

  task automatic send_desc(input work_desc_t d);
    result_desc_t want;
    want = '{tag: d.tag, slot: d.slot, sum: model_sum(d)};
    in_desc = d;
    in_valid = 1'b1;
    @(negedge clk);
    while (in_ready !== 1'b1) @(negedge clk);
    pend_q.push_back(want);
    n_sent++;
    @(posedge clk);
    #DRIVE_DLY;
    in_valid = 1'b0;
  endtask

  task automatic run_step(input step_t s);
    logic [DATA_W-1:0] rd;
    case (s.kind)
      OP_WR: host_write({s.slot, s.word}, s.data);
      OP_RD: begin
        wb_access(1'b0, {s.slot, s.word}, '0, rd);
        if (rd !== s.data) begin
          n_errors++;
          $display("ERROR %0t: read slot %0d word %0d got %h, expected %h",
                   $time, s.slot, s.word, rd, s.data);
        end
      end
      default: send_desc('{tag: s.tag, slot: s.slot, start: s.word, len: s.len});
    endcase
  endtask

  //////////////////////////////////////////////////
  // Result side

  // First pending entry of the same slot must match
  task automatic take_result(input result_desc_t got);
    int idx;
    idx = -1;
    for (int i = 0; i < pend_q.size(); i++) begin
      if (idx < 0 && pend_q[i].slot == got.slot) idx = i;
    end
    n_results++;
    if (idx < 0) begin
      n_errors++;
      $display("ERROR %0t: unexpected result tag %h from slot %0d", $time, got.tag, got.slot);
    end else begin
      if (got !== pend_q[idx]) begin
        n_errors++;
        $display("ERROR %0t: slot %0d got tag %h sum %h, expected tag %h sum %h", $time,
                 got.slot, got.tag, got.sum, pend_q[idx].tag, pend_q[idx].sum);
      end
      pend_q.delete(idx);
    end
  endtask

  always @(posedge clk) begin
    #DRIVE_DLY;
    rnd = lcg_next();
    out_ready = (rnd[31:30] != 2'b00);
  end

  always @(negedge clk) begin
    if (arst_n && out_valid && out_ready) take_result(out_desc);
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles: %0d errors, %0d results still outstanding",
               cycles, n_errors, pend_q.size());
      $display(">>> FAIL");
      $finish;
    end
  end

  initial begin
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_w = '0;
    in_desc = '0;
    in_valid = 1'b0;
    out_ready = 1'b0;
    load_steps();

    // Idle outputs through reset and before stimulus
    repeat (8) begin
      @(negedge clk);
      if (wb_ack !== 1'b0 || out_valid !== 1'b0) begin
        n_errors++;
        $display("ERROR %0t: wb_ack or out_valid high before stimulus", $time);
      end
    end
    @(posedge clk);
    #DRIVE_DLY;

    for (int a = 0; a < FILL_OPS; a++) begin
      host_write(ADR_W'(a), fill_word(ADR_W'(a)));
    end
    for (int i = 0; i < N_STEPS; i++) begin
      run_step(steps[i]);
    end

    while (pend_q.size() != 0) @(negedge clk);
    repeat (8) @(posedge clk);

    n_errors += u_dut.u_collect.u_checker.n_fail;
    $display("Done: %0d errors, %0d assertion failures, %0d of %0d results", n_errors,
             u_dut.u_collect.u_checker.n_fail, n_results, n_sent);
    if (n_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- cluster_top.f
logic/cluster_cfg_pkg.sv
logic/cluster_msg_pkg.sv
logic/pipe_reg.sv
logic/slot_core.sv
logic/slot_wrapper.sv
logic/slot_dispatch.sv
logic/result_collect.sv
logic/cluster_top.sv
test/tb_clock.sv
test/cluster_top_checker.sv
test/cluster_top_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= cluster_top_tb
FLIST     ?= cluster_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= >>> PASS

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN) $(RUN_ARGS))"; echo "$$out"; echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
